/* list.f */
+incdir+design
design/mem_pkg.sv
design/wb_pkg.sv
design/mem_ans_buffer.sv
design/mem_port_ctrl.sv
design/wb_arbiter.sv
design/wb_ram.sv
design/mem_subsys_top.sv
test/tb_clk_gen.sv
test/mem_subsys_chk.sv
test/mem_subsys_tb.sv

/* test/mem_subsys_tb.sv */
/*
 * Table-driven testbench for mem_subsys_top.
 * Inputs change on the falling edge; handshakes are judged there too.
 * Expected load values come from a byte-wide shadow of the RAM, updated
 * when a store is issued, so a fetch must not race a store to its word.
 */
`timescale 1ns/1ns
`include "mem_settings.svh"
`default_nettype none

module mem_subsys_tb
  import mem_pkg::*;
(
);

  typedef enum logic [2:0] {
    OP_REQ, OP_SYNC, OP_FLUSH, OP_HOLD, OP_RELEASE, OP_STALL, OP_NOSTALL
  } op_e;

  typedef struct packed {
    op_e                    op;
    logic                   port;
    mem_acc_e               acc;
    mem_ls_e                ls;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [31:0]            wdata;
    mem_exc_e               exp_exc;
  } entry_t;

  logic     clk_i, rst_n_i, flush_i;
  logic     ins_valid_i, ins_ready_i, ins_valid_o, ins_ready_o;
  logic     data_valid_i, data_ready_i, data_valid_o, data_ready_o;
  mem_req_t ins_req_i, data_req_i;
  mem_ans_t ins_ans_o, data_ans_o;

  entry_t     tbl[$];
  string      names[$];
  mem_ans_t   exp_q0[$], exp_q1[$];
  int         name_q0[$], name_q1[$];
  logic [7:0] shadow [4*`MEM_DEPTH_WORDS];
  logic [3:0] tag_cnt [2];
  bit         hold, stall;
  int         cycles, limit;

  tb_clk_gen #(.PERIOD_NS(40)) u_clk (.clk_o(clk_i));

  mem_subsys_top dut_i (.*);

  // Reporting
  // --------------------------------------------------
  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_tag(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (exp !== act) stop_on_failure($sformatf("Fail %s tag: expected %0d, actual %0d",
                                               name, exp, act));
  endtask

  task automatic check_acc(input string name, input mem_acc_e exp, input mem_acc_e act);
    if (exp !== act) stop_on_failure($sformatf("Fail %s access: expected %s, actual %s",
                                               name, exp.name(), act.name()));
  endtask

  task automatic check_addr(input string name, input logic [`MEM_ADDR_W-1:0] exp,
                            input logic [`MEM_ADDR_W-1:0] act);
    if (exp !== act) stop_on_failure($sformatf("Fail %s address: expected %h, actual %h",
                                               name, exp, act));
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) stop_on_failure($sformatf("Fail %s value: expected %h, actual %h",
                                               name, exp, act));
  endtask

  task automatic check_exc(input string name, input mem_exc_e exp, input mem_exc_e act,
                           input logic raised);
    if (exp !== act || raised !== (exp != E_NONE))
      stop_on_failure($sformatf("Fail %s exception: expected %s, actual %s (raised %b)",
                                name, exp.name(), act.name(), raised));
  endtask

  // Reference model
  // --------------------------------------------------
  // Little-endian lanes, loads sign or zero extended, stores update the shadow
  function automatic logic [31:0] expect_value(input entry_t e, input mem_acc_e acc);
    int unsigned a;
    int          n;
    logic [31:0] w;
    a = e.addr;
    if (e.exp_exc != E_NONE) return 32'b0;
    if (e.ls inside {LS_BYTE, LS_BYTE_U}) n = 1;
    else if (e.ls inside {LS_HALFWORD, LS_HALFWORD_U}) n = 2;
    else n = 4;
    if (acc == MEM_ACC_ST) begin
      for (int i = 0; i < n; i++) shadow[a + i] = e.wdata[8*i +: 8];
      return 32'b0;
    end
    w = {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
    if (acc == MEM_ACC_INSTR) return w;
    case (e.ls)
      LS_BYTE:       return {{24{w[7]}}, w[7:0]};
      LS_BYTE_U:     return {24'b0, w[7:0]};
      LS_HALFWORD:   return {{16{w[15]}}, w[15:0]};
      LS_HALFWORD_U: return {16'b0, w[15:0]};
      default:       return w;
    endcase
  endfunction

  // Table building
  // --------------------------------------------------
  task automatic add_entry(input string name, input logic port, input mem_acc_e acc,
                           input mem_ls_e ls, input int addr, input logic [31:0] wdata,
                           input mem_exc_e exc);
    entry_t e;
    e = '{op: OP_REQ, port: port, acc: acc, ls: ls, addr: addr[15:0], wdata: wdata,
          exp_exc: exc};
    tbl.push_back(e);
    names.push_back(name);
  endtask

  task automatic add_op(input op_e op);
    entry_t e;
    e    = '0;
    e.op = op;
    tbl.push_back(e);
    names.push_back(op.name());
  endtask

  // Driving and watching
  // --------------------------------------------------
  // Called at a falling edge, returns at the falling edge after acceptance
  task automatic issue_request(input entry_t e, input int idx);
    mem_req_t r;
    mem_ans_t a;
    r = '{tag: tag_cnt[e.port], acc_type: e.acc, ls_type: e.ls, addr: e.addr, value: e.wdata};
    tag_cnt[e.port] = tag_cnt[e.port] + 4'd1;
    a.tag           = r.tag;
    a.acc_type      = e.port ? e.acc : MEM_ACC_INSTR;
    a.addr          = e.addr;
    a.value         = expect_value(e, a.acc_type);
    a.except_raised = (e.exp_exc != E_NONE);
    a.except_code   = e.exp_exc;
    if (e.port) begin
      exp_q1.push_back(a);
      name_q1.push_back(idx);
      data_req_i   = r;
      data_valid_i = 1'b1;
      while (!data_ready_o) @(negedge clk_i);
      @(negedge clk_i);
      data_valid_i = 1'b0;
    end else begin
      exp_q0.push_back(a);
      name_q0.push_back(idx);
      ins_req_i   = r;
      ins_valid_i = 1'b1;
      while (!ins_ready_o) @(negedge clk_i);
      @(negedge clk_i);
      ins_valid_i = 1'b0;
    end
  endtask

  task automatic watch_port(input logic port);
    logic     rdy;
    mem_ans_t act, exp;
    int       idx;
    forever begin
      @(negedge clk_i);
      rdy = hold ? 1'b0 : (stall ? 1'($urandom_range(1, 0)) : 1'b1);
      if (port) data_ready_i = rdy;
      else ins_ready_i = rdy;
      act = port ? data_ans_o : ins_ans_o;
      if (rdy && (port ? data_valid_o : ins_valid_o)) begin
        if ((port ? exp_q1.size() : exp_q0.size()) == 0)
          stop_on_failure($sformatf("Port %0d gave an answer with tag %0d that nobody asked for",
                                    port, act.tag));
        exp = port ? exp_q1.pop_front() : exp_q0.pop_front();
        idx = port ? name_q1.pop_front() : name_q0.pop_front();
        check_tag(names[idx], exp.tag, act.tag);
        check_acc(names[idx], exp.acc_type, act.acc_type);
        check_addr(names[idx], exp.addr, act.addr);
        check_value(names[idx], exp.value, act.value);
        check_exc(names[idx], exp.except_code, act.except_code, act.except_raised);
      end
    end
  endtask

  // Timeout
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit)
      stop_on_failure("Timeout: the run did not finish within the cycle limit");
  end

  // Bound protocol assertions
  always @(negedge clk_i) begin
    if (dut_i.u_chk.fail_cnt != 0)
      stop_on_failure("A protocol assertion on the bus or an answer port failed");
  end

  initial begin
    void'($urandom(17));
    {flush_i, ins_valid_i, data_valid_i} = '0;
    rst_n_i = 1'b0;
    {ins_ready_i, data_ready_i} = 2'b11;
    ins_req_i = '0;
    data_req_i = '0;
    {hold, stall, cycles} = '0;
    tag_cnt = '{4'd0, 4'd0};
    for (int i = 0; i < 4*`MEM_DEPTH_WORDS; i++) shadow[i] = 8'h00;

    // Stores of each width, then loads of each width and sign
    add_entry("sw_100", 1, MEM_ACC_ST, LS_WORD, 'h100, 32'h8bad_f00d, E_NONE);
    add_entry("sb_104", 1, MEM_ACC_ST, LS_BYTE, 'h104, 32'h0000_0080, E_NONE);
    add_entry("sb_105", 1, MEM_ACC_ST, LS_BYTE_U, 'h105, 32'h0000_007f, E_NONE);
    add_entry("sh_106", 1, MEM_ACC_ST, LS_HALFWORD, 'h106, 32'h0000_9abc, E_NONE);
    add_entry("sh_108", 1, MEM_ACC_ST, LS_HALFWORD_U, 'h108, 32'h0000_1234, E_NONE);
    add_entry("sb_10b", 1, MEM_ACC_ST, LS_BYTE, 'h10b, 32'h0000_00f0, E_NONE);
    add_entry("lb_100", 1, MEM_ACC_LD, LS_BYTE, 'h100, 0, E_NONE);
    add_entry("lb_103", 1, MEM_ACC_LD, LS_BYTE, 'h103, 0, E_NONE);
    add_entry("lbu_103", 1, MEM_ACC_LD, LS_BYTE_U, 'h103, 0, E_NONE);
    add_entry("lh_102", 1, MEM_ACC_LD, LS_HALFWORD, 'h102, 0, E_NONE);
    add_entry("lhu_102", 1, MEM_ACC_LD, LS_HALFWORD_U, 'h102, 0, E_NONE);
    add_entry("lh_106", 1, MEM_ACC_LD, LS_HALFWORD, 'h106, 0, E_NONE);
    add_entry("lw_104", 1, MEM_ACC_LD, LS_WORD, 'h104, 0, E_NONE);
    add_entry("lw_108", 1, MEM_ACC_LD, LS_WORD, 'h108, 0, E_NONE);
    add_entry("lb_105", 1, MEM_ACC_LD, LS_BYTE, 'h105, 0, E_NONE);
    add_entry("lbu_10b", 1, MEM_ACC_LD, LS_BYTE_U, 'h10b, 0, E_NONE);
    add_op(OP_SYNC);
    // Fetches alongside load/store traffic
    add_entry("lw_par_108", 1, MEM_ACC_LD, LS_WORD, 'h108, 0, E_NONE);
    add_entry("if_100", 0, MEM_ACC_INSTR, LS_WORD, 'h100, 0, E_NONE);
    add_entry("sw_par_200", 1, MEM_ACC_ST, LS_WORD, 'h200, 32'hcafe_0042, E_NONE);
    add_entry("if_104", 0, MEM_ACC_LD, LS_BYTE, 'h104, 0, E_NONE);
    add_entry("lh_par_100", 1, MEM_ACC_LD, LS_HALFWORD, 'h100, 0, E_NONE);
    add_entry("if_108", 0, MEM_ACC_INSTR, LS_WORD, 'h108, 0, E_NONE);
    add_op(OP_SYNC);
    // Misaligned addresses, memory must stay as it was
    add_entry("lh_mis", 1, MEM_ACC_LD, LS_HALFWORD, 'h101, 0, E_LD_ADDR_MISALIGNED);
    add_entry("sh_mis", 1, MEM_ACC_ST, LS_HALFWORD, 'h107, 32'hffff, E_ST_ADDR_MISALIGNED);
    add_entry("sw_mis", 1, MEM_ACC_ST, LS_WORD, 'h102, 32'h1111_2222, E_ST_ADDR_MISALIGNED);
    add_entry("lw_mis", 1, MEM_ACC_LD, LS_WORD, 'h103, 0, E_LD_ADDR_MISALIGNED);
    add_entry("if_mis", 0, MEM_ACC_INSTR, LS_WORD, 'h102, 0, E_I_ADDR_MISALIGNED);
    add_entry("lw_after_mis", 1, MEM_ACC_LD, LS_WORD, 'h100, 0, E_NONE);
    add_entry("lw_after_mis2", 1, MEM_ACC_LD, LS_WORD, 'h104, 0, E_NONE);
    add_op(OP_SYNC);
    // Out of range
    add_entry("lw_oor", 1, MEM_ACC_LD, LS_WORD, 'h1000, 0, E_LD_ACCESS_FAULT);
    add_entry("sw_oor", 1, MEM_ACC_ST, LS_WORD, 'h1000, 32'h5555_aaaa, E_ST_ACCESS_FAULT);
    add_entry("if_oor", 0, MEM_ACC_INSTR, LS_WORD, 'h2000, 0, E_I_ACCESS_FAULT);
    add_entry("lb_oor", 1, MEM_ACC_LD, LS_BYTE, 'hfffc, 0, E_LD_ACCESS_FAULT);
    add_entry("sb_oor", 1, MEM_ACC_ST, LS_BYTE, 'h1003, 32'h77, E_ST_ACCESS_FAULT);
    add_entry("lw_last", 1, MEM_ACC_LD, LS_WORD, 'h0ffc, 0, E_NONE);
    // Faulting stores above must not wrap onto word 0
    add_entry("lw_alias_0", 1, MEM_ACC_LD, LS_WORD, 'h0000, 0, E_NONE);
    add_op(OP_SYNC);
    // Random back-pressure
    add_op(OP_STALL);
    for (int i = 0; i < 4; i++) begin
      add_entry($sformatf("sw_bp_%0d", i), 1, MEM_ACC_ST, LS_WORD, 'h300 + 4*i,
                32'h1234_5678 ^ (32'h0101_0101 * i), E_NONE);
    end
    for (int i = 0; i < 4; i++) begin
      add_entry($sformatf("lw_bp_%0d", i), 1, MEM_ACC_LD, LS_WORD, 'h300 + 4*i, 0, E_NONE);
      add_entry($sformatf("if_bp_%0d", i), 0, MEM_ACC_INSTR, LS_WORD, 'h100 + 4*i, 0, E_NONE);
    end
    add_op(OP_SYNC);
    add_op(OP_NOSTALL);
    // Flush with answers buffered and a cycle in flight
    add_op(OP_HOLD);
    add_entry("if_fl_0", 0, MEM_ACC_INSTR, LS_WORD, 'h300, 0, E_NONE);
    add_entry("if_fl_1", 0, MEM_ACC_INSTR, LS_WORD, 'h304, 0, E_NONE);
    add_entry("lw_fl_0", 1, MEM_ACC_LD, LS_WORD, 'h100, 0, E_NONE);
    add_entry("lw_fl_1", 1, MEM_ACC_LD, LS_WORD, 'h104, 0, E_NONE);
    add_op(OP_FLUSH);
    add_op(OP_RELEASE);
    add_entry("lw_post_fl", 1, MEM_ACC_LD, LS_WORD, 'h104, 0, E_NONE);
    add_entry("if_post_fl", 0, MEM_ACC_INSTR, LS_WORD, 'h308, 0, E_NONE);
    add_op(OP_SYNC);

    limit = tbl.size() * 20 + 16;

    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    if (ins_valid_o || data_valid_o || !ins_ready_o || !data_ready_o)
      stop_on_failure("Port handshake signals are wrong after reset");

    fork
      watch_port(1'b0);
      watch_port(1'b1);
    join_none

    foreach (tbl[i]) begin
      case (tbl[i].op)
        OP_REQ: issue_request(tbl[i], i);
        OP_SYNC: begin
          while (exp_q0.size() != 0 || exp_q1.size() != 0) @(negedge clk_i);
        end
        OP_FLUSH: begin
          flush_i = 1'b1;
          exp_q0.delete();
          exp_q1.delete();
          name_q0.delete();
          name_q1.delete();
          @(negedge clk_i);
          flush_i = 1'b0;
        end
        OP_HOLD: begin
          hold = 1'b1;
          @(negedge clk_i);
        end
        OP_RELEASE: hold = 1'b0;
        OP_STALL: stall = 1'b1;
        default: stall = 1'b0;
      endcase
    end

    repeat (8) @(negedge clk_i);
    if (exp_q0.size() == 0 && exp_q1.size() == 0 && !ins_valid_o && !data_valid_o) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Answers missing or left over at the end of the run");
      $display("Test failures found");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

/* test/mem_subsys_chk.sv */
/*
 * Protocol assertions on the shared Wishbone bus and both answer ports.
 * Bound into mem_subsys_top; the answer-hold check is skipped in flush cycles.
 */
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_chk
  import mem_pkg::*;
  import wb_pkg::*;
(
  input logic     clk_i,
  input logic     rst_n_i,
  input logic     flush_i,
  input wb_m2s_t  ram_m2s,
  input wb_s2m_t  ram_s2m,
  input logic     ins_valid_o,
  input logic     ins_ready_i,
  input mem_ans_t ins_ans_o,
  input logic     data_valid_o,
  input logic     data_ready_i,
  input mem_ans_t data_ans_o
);

  int unsigned fail_cnt = 0;

  // Bus rules
  // --------------------------------------------------
  stb_needs_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ram_m2s.stb |-> ram_m2s.cyc)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("stb high without cyc");
    end

  ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ram_s2m.ack && ram_s2m.err))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("ack and err high together");
    end

  adr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ram_m2s.stb && !ram_s2m.ack && !ram_s2m.err) |=> $stable(ram_m2s.adr))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("address changed while stb waited");
    end

  // Answer ports hold under back-pressure
  // --------------------------------------------------
  ins_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ins_valid_o && !ins_ready_i && !flush_i) |=> (ins_valid_o && $stable(ins_ans_o)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("fetch answer dropped or changed before ready");
    end

  data_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (data_valid_o && !data_ready_i && !flush_i) |=> (data_valid_o && $stable(data_ans_o)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("load/store answer dropped or changed before ready");
    end

endmodule

bind mem_subsys_top mem_subsys_chk u_chk (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .ram_m2s     (ram_m2s),
  .ram_s2m     (ram_s2m),
  .ins_valid_o (ins_valid_o),
  .ins_ready_i (ins_ready_i),
  .ins_ans_o   (ins_ans_o),
  .data_valid_o(data_valid_o),
  .data_ready_i(data_ready_i),
  .data_ans_o  (data_ans_o)
);

`default_nettype wire

/* test/tb_clk_gen.sv */
/*
 * Free-running testbench clock, starts low.
 * PERIOD_NS should be even.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* design/mem_subsys_top.sv */
/*
 * Memory subsystem: fetch and load/store ports sharing one RAM.
 * Fetch port is master 0 of the arbiter.
 * flush_i applies to both ports.
 */
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top
  import mem_pkg::*;
  import wb_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,

  // Fetch port
  input  logic     ins_valid_i,
  input  logic     ins_ready_i,
  output logic     ins_valid_o,
  output logic     ins_ready_o,
  input  mem_req_t ins_req_i,
  output mem_ans_t ins_ans_o,

  // Load/store port
  input  logic     data_valid_i,
  input  logic     data_ready_i,
  output logic     data_valid_o,
  output logic     data_ready_o,
  input  mem_req_t data_req_i,
  output mem_ans_t data_ans_o
);

  wb_m2s_t ins_m2s, data_m2s, ram_m2s;
  wb_s2m_t ins_s2m, data_s2m, ram_s2m;

  mem_port_ctrl #(.FETCH_ONLY(1'b1)) u_ins_port (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .req_valid_i(ins_valid_i),
    .req_ready_o(ins_ready_o),
    .req_i      (ins_req_i),
    .ans_valid_o(ins_valid_o),
    .ans_ready_i(ins_ready_i),
    .ans_o      (ins_ans_o),
    .wb_o       (ins_m2s),
    .wb_i       (ins_s2m)
  );

  mem_port_ctrl #(.FETCH_ONLY(1'b0)) u_data_port (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .req_valid_i(data_valid_i),
    .req_ready_o(data_ready_o),
    .req_i      (data_req_i),
    .ans_valid_o(data_valid_o),
    .ans_ready_i(data_ready_i),
    .ans_o      (data_ans_o),
    .wb_o       (data_m2s),
    .wb_i       (data_s2m)
  );

  wb_arbiter u_arbiter (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .m0_i   (ins_m2s),
    .m1_i   (data_m2s),
    .m0_o   (ins_s2m),
    .m1_o   (data_s2m),
    .s_o    (ram_m2s),
    .s_i    (ram_s2m)
  );

  wb_ram u_ram (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .wb_i   (ram_m2s),
    .wb_o   (ram_s2m)
  );

endmodule

`default_nettype wire

/* design/wb_ram.sv */
/*
 * Single-ported Wishbone classic RAM, MEM_DEPTH_WORDS words of 32 bits.
 * Answers one cycle after stb; ack and err last one cycle.
 * Word addresses beyond the array get err and never write.
 * Contents start at zero; sel is ignored on reads.
 */
`timescale 1ns/1ns
`include "mem_settings.svh"
`default_nettype none

module wb_ram
  import wb_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  wb_m2s_t wb_i,
  output wb_s2m_t wb_o
);

  localparam int unsigned IDX_W = $clog2(`MEM_DEPTH_WORDS);

  wb_data_u             mem_q [`MEM_DEPTH_WORDS] = '{default: '0};
  wb_data_u             rdata_q;
  logic                 ack_q, err_q;
  logic                 hit, in_range;
  logic [IDX_W-1:0]     idx;

  // New access only when nothing is pending
  assign hit      = wb_i.cyc & wb_i.stb & ~(ack_q | err_q);
  assign in_range = (wb_i.adr < 30'(`MEM_DEPTH_WORDS));
  assign idx      = wb_i.adr[IDX_W-1:0];

  // Handshake
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= hit & in_range;
      err_q <= hit & ~in_range;
    end
  end

  // Array
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (hit && in_range) begin
      if (wb_i.we) begin
        for (int i = 0; i < 4; i++) begin
          if (wb_i.sel[i]) mem_q[idx].lane[i] <= wb_i.dat.lane[i];
        end
      end
      // Old word on a write, never seen by the ports
      rdata_q <= mem_q[idx];
    end
  end

  assign wb_o.ack = ack_q;
  assign wb_o.err = err_q;
  assign wb_o.dat = rdata_q;

endmodule

`default_nettype wire

/* design/wb_arbiter.sv */
/*
 * Two-master Wishbone arbiter, round robin.
 * While the bus is idle the choice is combinational, so no cycle is added.
 * The grant stays locked from the first stb until ack or err.
 * Master 0 is the fetch port.
 */
`timescale 1ns/1ns
`include "mem_settings.svh"
`default_nettype none

module wb_arbiter
  import wb_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  wb_m2s_t m0_i,
  input  wb_m2s_t m1_i,
  output wb_s2m_t m0_o,
  output wb_s2m_t m1_o,
  output wb_m2s_t s_o,
  input  wb_s2m_t s_i
);

  logic locked_q, gnt_q, last_q;
  logic pick, gnt;

  // Idle choice
  // --------------------------------------------------
  // On a tie the master not served last wins
  always_comb begin
    if (m0_i.cyc && m1_i.cyc) pick = ~last_q;
    else                      pick = m1_i.cyc;
  end

  assign gnt = locked_q ? gnt_q : pick;

  // Grant lock
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      locked_q <= 1'b0;
      gnt_q    <= 1'b0;
      last_q   <= `WB_ARB_LAST_RST;
    end else begin
      gnt_q    <= gnt;
      // Released on the edge where the slave answers
      locked_q <= s_o.cyc & ~(s_i.ack | s_i.err);
      if (!locked_q && s_o.cyc) last_q <= gnt;
    end
  end

  // Routing
  // --------------------------------------------------
  assign s_o = gnt ? m1_i : m0_i;

  always_comb begin
    m0_o     = s_i;
    m0_o.ack = s_i.ack & ~gnt;
    m0_o.err = s_i.err & ~gnt;
    m1_o     = s_i;
    m1_o.ack = s_i.ack & gnt;
    m1_o.err = s_i.err & gnt;
  end

endmodule

`default_nettype wire

/* design/mem_port_ctrl.sv */
/*
 * One core port: alignment check, Wishbone classic master, answer buffer.
 * One bus cycle at a time; a misaligned address never reaches the bus.
 * With FETCH_ONLY set, every request is handled as a word fetch.
 * A flush also drops any request accepted in the flush cycle.
 */
`timescale 1ns/1ns
`include "mem_settings.svh"
`default_nettype none

module mem_port_ctrl
  import mem_pkg::*;
  import wb_pkg::*;
#(
  parameter bit FETCH_ONLY = 1'b0
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  mem_req_t req_i,
  output logic     ans_valid_o,
  input  logic     ans_ready_i,
  output mem_ans_t ans_o,
  output wb_m2s_t  wb_o,
  input  wb_s2m_t  wb_i
);

  mem_req_t req_eff, req_q;
  logic     busy_q, cancel_q;
  logic     buf_ready, misaligned, acc_fire, bus_done;
  mem_ans_t mis_ans, bus_ans;
  wb_data_u st_src, st_dat;
  logic [3:0]  sel;
  logic [1:0]  off;
  logic [15:0] hw;
  logic [31:0] ld_val;

  function automatic mem_exc_e exc_code(input mem_acc_e acc, input logic fault);
    case (acc)
      MEM_ACC_INSTR: return fault ? E_I_ACCESS_FAULT : E_I_ADDR_MISALIGNED;
      MEM_ACC_ST:    return fault ? E_ST_ACCESS_FAULT : E_ST_ADDR_MISALIGNED;
      default:       return fault ? E_LD_ACCESS_FAULT : E_LD_ADDR_MISALIGNED;
    endcase
  endfunction

  // Request checking
  // --------------------------------------------------
  always_comb begin
    req_eff = req_i;
    if (FETCH_ONLY) req_eff.acc_type = MEM_ACC_INSTR;
    if (req_eff.acc_type == MEM_ACC_INSTR) req_eff.ls_type = LS_WORD;
    case (req_eff.ls_type)
      LS_HALFWORD, LS_HALFWORD_U: misaligned = req_eff.addr[0];
      LS_WORD:                    misaligned = |req_eff.addr[1:0];
      default:                    misaligned = 1'b0;
    endcase
  end

  assign req_ready_o = ~busy_q & buf_ready;
  assign acc_fire    = req_valid_i & req_ready_o;
  assign bus_done    = busy_q & (wb_i.ack | wb_i.err);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q   <= 1'b0;
      cancel_q <= 1'b0;
    end else begin
      if (bus_done) busy_q <= 1'b0;
      else if (acc_fire && !misaligned) busy_q <= 1'b1;
      // Answer of the cycle in flight is dropped once it completes
      if (bus_done) cancel_q <= 1'b0;
      else if (flush_i && (busy_q || (acc_fire && !misaligned))) cancel_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_fire) req_q <= req_eff;
  end

  // Wishbone master
  // --------------------------------------------------
  assign off        = req_q.addr[1:0];
  assign st_src.word = req_q.value;

  // Byte select and store lanes
  always_comb begin
    st_dat.word = '0;
    case (req_q.ls_type)
      LS_BYTE, LS_BYTE_U: begin
        sel              = 4'b0001 << off;
        st_dat.lane[off] = st_src.lane[0];
      end
      LS_HALFWORD, LS_HALFWORD_U: begin
        sel                          = 4'b0011 << off;
        st_dat.lane[{off[1], 1'b0}] = st_src.lane[0];
        st_dat.lane[{off[1], 1'b1}] = st_src.lane[1];
      end
      default: begin
        sel         = 4'b1111;
        st_dat.word = st_src.word;
      end
    endcase
  end

  always_comb begin
    wb_o.cyc = busy_q;
    wb_o.stb = busy_q;
    wb_o.we  = (req_q.acc_type == MEM_ACC_ST);
    wb_o.adr = {{(32 - `MEM_ADDR_W){1'b0}}, req_q.addr[`MEM_ADDR_W-1:2]};
    wb_o.sel = sel;
    wb_o.dat = wb_o.we ? st_dat : '0;
  end

  // Answer building
  // --------------------------------------------------
  assign hw = off[1] ? wb_i.dat.word[31:16] : wb_i.dat.word[15:0];

  always_comb begin
    case (req_q.ls_type)
      LS_BYTE:       ld_val = {{24{wb_i.dat.lane[off][7]}}, wb_i.dat.lane[off]};
      LS_BYTE_U:     ld_val = {24'b0, wb_i.dat.lane[off]};
      LS_HALFWORD:   ld_val = {{16{hw[15]}}, hw};
      LS_HALFWORD_U: ld_val = {16'b0, hw};
      default:       ld_val = wb_i.dat.word;
    endcase
  end

  always_comb begin
    mis_ans.tag           = req_eff.tag;
    mis_ans.acc_type      = req_eff.acc_type;
    mis_ans.addr          = req_eff.addr;
    mis_ans.value         = '0;
    mis_ans.except_raised = 1'b1;
    mis_ans.except_code   = exc_code(req_eff.acc_type, 1'b0);

    bus_ans.tag           = req_q.tag;
    bus_ans.acc_type      = req_q.acc_type;
    bus_ans.addr          = req_q.addr;
    bus_ans.value         = (wb_i.err || wb_o.we) ? 32'b0 : ld_val;
    bus_ans.except_raised = wb_i.err;
    bus_ans.except_code   = wb_i.err ? exc_code(req_q.acc_type, 1'b1) : E_NONE;
  end

  mem_ans_buffer u_ans_buf (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .flush_i(flush_i),
    .valid_i((acc_fire & misaligned) | (bus_done & ~cancel_q)),
    .ready_o(buf_ready),
    .data_i (busy_q ? bus_ans : mis_ans),
    .valid_o(ans_valid_o),
    .ready_i(ans_ready_i),
    .data_o (ans_o)
  );

endmodule

`default_nettype wire

/* design/mem_ans_buffer.sv */
/*
 * Two-entry spill buffer for answers toward the core.
 * ready_o depends on occupancy only, never on ready_i.
 * flush_i drops both entries, including a word pushed in the same cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module mem_ans_buffer
  import mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  mem_ans_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output mem_ans_t data_o
);

  logic     out_valid_q, spill_valid_q;
  mem_ans_t out_data_q, spill_data_q;
  logic     push, pop;

  assign ready_o = ~spill_valid_q;
  assign push    = valid_i & ~spill_valid_q;
  assign pop     = out_valid_q & ready_i;

  // Valid flags
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      out_valid_q   <= 1'b0;
      spill_valid_q <= 1'b0;
    end else if (!out_valid_q || pop) begin
      // Output slot frees up, spill entry moves forward first
      out_valid_q   <= spill_valid_q | push;
      spill_valid_q <= 1'b0;
    end else if (push) begin
      spill_valid_q <= 1'b1;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (!out_valid_q || pop) begin
      out_data_q <= spill_valid_q ? spill_data_q : data_i;
    end else if (push) begin
      spill_data_q <= data_i;
    end
  end

  assign valid_o = out_valid_q;
  assign data_o  = out_data_q;

endmodule

`default_nettype wire

/* design/wb_pkg.sv */
/*
 * Wishbone classic bus types.
 * The address is a word address of a 32-bit byte space.
 * Byte lane 0 is bits 7:0 (little endian).
 */
`default_nettype none

package wb_pkg;

  // One data word, seen whole or as byte lanes
  typedef union packed {
    logic [31:0]      word;
    logic [3:0][7:0]  lane;
  } wb_data_u;

  // Master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [29:0] adr;
    logic [3:0]  sel;
    wb_data_u    dat;
  } wb_m2s_t;

  // Slave to master
  typedef struct packed {
    logic     ack;
    logic     err;
    wb_data_u dat;
  } wb_s2m_t;

endpackage

`default_nettype wire

/* design/mem_pkg.sv */
/*
 * Core-side types shared by the port controllers and the top level.
 * Doubleword accesses are not supported.
 * Address width comes from the settings header.
 */
`include "mem_settings.svh"
`default_nettype none

package mem_pkg;

  // Access kinds
  typedef enum logic [1:0] {
    MEM_ACC_INSTR = 2'd0,
    MEM_ACC_LD    = 2'd1,
    MEM_ACC_ST    = 2'd2
  } mem_acc_e;

  // Load/store width and signedness
  typedef enum logic [2:0] {
    LS_BYTE       = 3'd0,
    LS_BYTE_U     = 3'd1,
    LS_HALFWORD   = 3'd2,
    LS_HALFWORD_U = 3'd3,
    LS_WORD       = 3'd4
  } mem_ls_e;

  // Exception codes returned with an answer
  typedef enum logic [2:0] {
    E_NONE               = 3'd0,
    E_I_ADDR_MISALIGNED  = 3'd1,
    E_I_ACCESS_FAULT     = 3'd2,
    E_LD_ADDR_MISALIGNED = 3'd3,
    E_LD_ACCESS_FAULT    = 3'd4,
    E_ST_ADDR_MISALIGNED = 3'd5,
    E_ST_ACCESS_FAULT    = 3'd6
  } mem_exc_e;

  typedef struct packed {
    logic [3:0]             tag;
    mem_acc_e               acc_type;
    mem_ls_e                ls_type;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [31:0]            value;
  } mem_req_t;

  typedef struct packed {
    logic [3:0]             tag;
    mem_acc_e               acc_type;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [31:0]            value;
    logic                   except_raised;
    mem_exc_e               except_code;
  } mem_ans_t;

endpackage

`default_nettype wire

/* design/mem_settings.svh */
/*
 * Build-time settings for the memory subsystem.
 * The byte address is MEM_ADDR_W bits wide; the RAM holds MEM_DEPTH_WORDS
 * 32-bit words, so any byte address at or above 4*MEM_DEPTH_WORDS faults.
 * WB_ARB_LAST_RST sets which master counts as served last after reset.
 */
`ifndef MEM_SETTINGS_SVH_
`define MEM_SETTINGS_SVH_

// Core-side byte address width
`define MEM_ADDR_W 16

// RAM size in 32-bit words
`define MEM_DEPTH_WORDS 1024

// Arbiter policy: 1'b1 lets master 0 (fetch) win the first tie after reset
`define WB_ARB_LAST_RST 1'b1

`endif
